// File: dv/gf3m_ref.svh
`ifndef GF3M_REF_SVH
`define GF3M_REF_SVH

// software model of GF(3^M) with x^M = 2x^K + 1, uses M and K of the including module

function automatic int trit_to_int(input logic [1:0] t);
    return (t == 2'b01) ? 1 : ((t == 2'b10) ? 2 : 0);
endfunction

function automatic logic [1:0] int_to_trit(input int v);
    case (v % 3)
        1:       return 2'b01;
        2:       return 2'b10;
        default: return 2'b00;
    endcase
endfunction

function automatic logic [2*M-1:0] add_elements(input logic [2*M-1:0] x,
                                                input logic [2*M-1:0] y);
    logic [2*M-1:0] r;
    for (int i = 0; i < M; i++)
        r[2*i +: 2] = int_to_trit(trit_to_int(x[2*i +: 2]) + trit_to_int(y[2*i +: 2]));
    return r;
endfunction

function automatic logic [2*M-1:0] sub_elements(input logic [2*M-1:0] x,
                                                input logic [2*M-1:0] y);
    logic [2*M-1:0] r;
    for (int i = 0; i < M; i++)
        r[2*i +: 2] = int_to_trit(3 + trit_to_int(x[2*i +: 2]) - trit_to_int(y[2*i +: 2]));
    return r;
endfunction

function automatic logic [2*M-1:0] negate_element(input logic [2*M-1:0] x);
    logic [2*M-1:0] r;
    for (int i = 0; i < M; i++)
        r[2*i +: 2] = int_to_trit(3 - trit_to_int(x[2*i +: 2]));
    return r;
endfunction

// schoolbook product, then fold from the top degree down
function automatic logic [2*M-1:0] mul_elements(input logic [2*M-1:0] x,
                                                input logic [2*M-1:0] y);
    int             p [0:2*M-2];
    int             c;
    logic [2*M-1:0] r;
    for (int i = 0; i < 2*M-1; i++)
        p[i] = 0;
    for (int i = 0; i < M; i++)
        for (int j = 0; j < M; j++)
            p[i+j] += trit_to_int(x[2*i +: 2]) * trit_to_int(y[2*j +: 2]);
    for (int d = 2*M-2; d >= M; d--)
    begin
        c = p[d] % 3;
        p[d] = 0;
        p[d-M] += c;
        p[d-M+K] += 2*c;
    end
    for (int i = 0; i < M; i++)
        r[2*i +: 2] = int_to_trit(p[i]);
    return r;
endfunction

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

// File: dv/gf3m_alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gf3m_alu_tb
    import alu_op_pkg::*;
();

    localparam int M = 97;
    localparam int K = 12;
    localparam int clk_period = 20;
    localparam int mul_cmds = 13;
    localparam int other_cmds = 79; // includes idle stretches and reset
    localparam int watchdog_cycles = 2 * (mul_cmds * (M + 4) + other_cmds * 6);

    `include "gf3m_ref.svh"

    logic               clk;
    logic               reset;
    logic               start;
    logic [op_bits-1:0] op;
    logic [2*M-1:0]     a;
    logic [2*M-1:0]     b;
    logic [2*M-1:0]     result;
    logic               busy;
    logic               done;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;

    gf3m_alu #(
        .M (M),
        .K (K)
    ) gf3m_alu_inst (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .result (result),
        .busy   (busy),
        .done   (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period/2) clk = ~clk;
    end

    initial
    begin
        #(watchdog_cycles * clk_period);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [2*M-1:0] expected,
                               input logic [2*M-1:0] actual);
        checks++;
        if (actual !== expected)
        begin
            $display("FAILED %s: expected %0h, got %0h", name, expected, actual);
            errors++;
        end
    endtask

    // two bits per trit and 11 folds to 00
    task automatic random_element(output logic [2*M-1:0] e);
        logic [1:0] t;
        for (int i = 0; i < M; i++)
        begin
            for (int j = 0; j < 2; j++)
            begin
                lfsr_state = lfsr_next(lfsr_state);
                t[j] = lfsr_state[0];
            end
            e[2*i +: 2] = (t == 2'b11) ? 2'b00 : t;
        end
    endtask

    task automatic wait_for_done(input int limit, output int edges);
        edges = 0;
        while (1)
        begin
            @(negedge clk);
            edges++;
            start = 1'b0;
            if (done && !busy)
                break;
            if (edges >= limit)
            begin
                $display("done did not rise within %0d cycles", limit);
                errors++;
                break;
            end
        end
    endtask

    task automatic run_command(input logic [op_bits-1:0] code, input logic [2*M-1:0] x,
                               input logic [2*M-1:0] y, output int edges);
        @(negedge clk);
        start = 1'b1;
        op    = code;
        a     = x;
        b     = y;
        wait_for_done(M + 10, edges);
    endtask

    task automatic linear_ops_test();
        logic [2*M-1:0] x;
        logic [2*M-1:0] y;
        int             edges;
        for (int n = 0; n < 20; n++)
        begin
            random_element(x);
            random_element(y);
            run_command(op_add, x, y, edges);
            check_value("done_edges", 3, edges);
            check_value("result", add_elements(x, y), result);
            run_command(op_sub, x, y, edges);
            check_value("done_edges", 3, edges);
            check_value("result", sub_elements(x, y), result);
            run_command(op_neg, x, y, edges);
            check_value("done_edges", 3, edges);
            check_value("result", negate_element(x), result);
        end
    endtask

    task automatic cube_test();
        logic [2*M-1:0] x;
        int             edges;
        for (int n = 0; n < 12; n++)
        begin
            if (n < 10)
                random_element(x);
            else
            begin
                x = '0;
                x[2*((n == 10) ? (M-1) : 33) +: 2] = 2'b01; // x^96 and x^33
            end
            run_command(op_cube, x, '0, edges);
            check_value("done_edges", 3, edges);
            check_value("result", mul_elements(mul_elements(x, x), x), result);
        end
    endtask

    task automatic mult_test();
        logic [2*M-1:0] x;
        logic [2*M-1:0] y;
        int             edges;
        for (int n = 0; n < 10; n++)
        begin
            random_element(x);
            random_element(y);
            run_command(op_mul, x, y, edges);
            check_value("done_edges", M + 2, edges);
            check_value("result", mul_elements(x, y), result);
        end
        y = '0;
        y[1:0] = 2'b01;
        run_command(op_mul, x, y, edges);
        check_value("result", x, result);
        run_command(op_mul, x, '0, edges);
        check_value("result", '0, result);
    endtask

    task automatic reject_test();
        logic [2*M-1:0] x;
        logic [2*M-1:0] y;
        logic [2*M-1:0] held;
        logic           prev_done;
        int             rises;
        int             cyc;
        random_element(x);
        random_element(y);
        @(negedge clk);
        start     = 1'b1;
        op        = op_mul;
        a         = x;
        b         = y;
        prev_done = done;
        rises     = 0;
        cyc       = 0;
        while (cyc < M + 25)
        begin
            @(negedge clk);
            cyc++;
            start = (cyc == 5); // second start lands while busy
            if (cyc == 5)
            begin
                op = op_mul;
                a  = y;
                b  = y;
            end
            if (done && !prev_done)
                rises++;
            prev_done = done;
        end
        check_value("done_rises", 1, rises);
        check_value("busy", 0, busy);
        check_value("result", mul_elements(x, y), result);

        // illegal code with done high
        held = mul_elements(x, y);
        @(negedge clk);
        start = 1'b1;
        op    = 3'd5;
        for (int n = 0; n < 5; n++)
        begin
            @(negedge clk);
            start = 1'b0;
            check_value("busy", 0, busy);
            check_value("done", 1, done);
            check_value("result", held, result);
        end
    endtask

    task automatic hold_test();
        logic [2*M-1:0] x;
        logic [2*M-1:0] y;
        int             edges;
        random_element(x);
        random_element(y);
        run_command(op_add, x, y, edges);
        for (int n = 0; n < 5; n++)
        begin
            @(negedge clk);
            check_value("done", 1, done);
            check_value("result", add_elements(x, y), result);
        end
        @(negedge clk);
        start = 1'b1;
        op    = op_sub;
        a     = x;
        b     = y;
        @(negedge clk);
        start = 1'b0;
        check_value("busy", 1, busy);
        @(negedge clk);
        check_value("done", 0, done);
        wait_for_done(M + 10, edges);
        check_value("result", sub_elements(x, y), result);
    endtask

    initial
    begin
        start      = 1'b0;
        op         = '0;
        a          = '0;
        b          = '0;
        reset      = 1'b1;
        errors     = 0;
        checks     = 0;
        lfsr_state = 32'hbd80;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("busy", 0, busy);
        check_value("done", 0, done);
        check_value("result", '0, result);

        linear_ops_test();
        cube_test();
        mult_test();
        reject_test();
        hold_test();

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/alu_op_pkg.sv
`default_nettype none

package alu_op_pkg;

    localparam int op_bits = 3;

    localparam logic [op_bits-1:0] op_add  = 3'd0;
    localparam logic [op_bits-1:0] op_sub  = 3'd1;
    localparam logic [op_bits-1:0] op_neg  = 3'd2;
    localparam logic [op_bits-1:0] op_cube = 3'd3;
    localparam logic [op_bits-1:0] op_mul  = 3'd4; // highest legal code

endpackage

`default_nettype wire

// File: logic/exec_if.sv
`timescale 1ns/1ps
`default_nettype none

interface exec_if
    import alu_op_pkg::*;
#(
    parameter int M = 97
);

    logic               go; // one cycle per accepted command
    logic [op_bits-1:0] op;
    logic [2*M-1:0]     a;
    logic [2*M-1:0]     b;

    modport issue (
        output go,
        output op,
        output a,
        output b
    );

    modport run (
        input go,
        input op,
        input a,
        input b
    );

    // only needs to know when a new command starts
    modport watch (
        input go
    );

endinterface

`default_nettype wire

// File: logic/gf3_pkg.sv
`default_nettype none

package gf3_pkg;

    localparam int trit_bits = 2;

    localparam logic [trit_bits-1:0] trit_zero = 2'b00;
    localparam logic [trit_bits-1:0] trit_one  = 2'b01;
    localparam logic [trit_bits-1:0] trit_two  = 2'b10;

    function automatic logic [trit_bits-1:0] trit_add(input logic [trit_bits-1:0] a,
                                                      input logic [trit_bits-1:0] b);
        case ({a, b})
            4'b0000, 4'b0110, 4'b1001: trit_add = trit_zero;
            4'b0001, 4'b0100, 4'b1010: trit_add = trit_one;
            4'b0010, 4'b0101, 4'b1000: trit_add = trit_two;
            default:                   trit_add = trit_zero; // 11 is not a trit
        endcase
    endfunction

    function automatic logic [trit_bits-1:0] trit_sub(input logic [trit_bits-1:0] a,
                                                      input logic [trit_bits-1:0] b);
        case ({a, b})
            4'b0000, 4'b0101, 4'b1010: trit_sub = trit_zero;
            4'b0100, 4'b1001, 4'b0010: trit_sub = trit_one;
            4'b0001, 4'b0110, 4'b1000: trit_sub = trit_two;
            default:                   trit_sub = trit_zero;
        endcase
    endfunction

    function automatic logic [trit_bits-1:0] trit_mul(input logic [trit_bits-1:0] a,
                                                      input logic [trit_bits-1:0] b);
        case ({a, b})
            4'b0101, 4'b1010: trit_mul = trit_one;
            4'b0110, 4'b1001: trit_mul = trit_two;
            default:          trit_mul = trit_zero; // anything times zero
        endcase
    endfunction

    // -1 = 2 and -2 = 1, so swapping the bits is enough
    function automatic logic [trit_bits-1:0] trit_neg(input logic [trit_bits-1:0] a);
        trit_neg = {a[0], a[1]};
    endfunction

endpackage

`default_nettype wire

// File: logic/gf3m_alu.sv
`timescale 1ns/1ps
`default_nettype none

module gf3m_alu
    import alu_op_pkg::*;
#(
    parameter int M = 97,
    parameter int K = 12
)
(
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic [op_bits-1:0] op,
    input  logic [2*M-1:0]     a,
    input  logic [2*M-1:0]     b,
    output logic [2*M-1:0]     result,
    output logic               busy,
    output logic               done
);

    logic           value_valid;
    logic [2*M-1:0] value;

    exec_if #(.M(M)) cmd_if ();

    op_decode #(
        .M (M)
    ) decode_inst (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .op          (op),
        .a           (a),
        .b           (b),
        .value_valid (value_valid),
        .busy        (busy),
        .cmd         (cmd_if.issue)
    );

    gf3m_execute #(
        .M (M),
        .K (K)
    ) execute_inst (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd_if.run),
        .value_valid (value_valid),
        .value       (value)
    );

    result_hold #(
        .M (M)
    ) hold_inst (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd_if.watch),
        .value_valid (value_valid),
        .value       (value),
        .result      (result),
        .done        (done)
    );

endmodule

`default_nettype wire

// File: logic/gf3m_cube.sv
`timescale 1ns/1ps
`default_nettype none

module gf3m_cube
    import gf3_pkg::*;
#(
    parameter int M = 97,
    parameter int K = 12
)
(
    input  logic [2*M-1:0] a,
    output logic [2*M-1:0] cube
);

    localparam int W = 3*M - 2; // trits in the unreduced cube

    // clear trit d and push it down as x^(d-M) * (2x^K + 1)
    function automatic logic [2*W-1:0] fold_step(input logic [2*W-1:0] v, input int d);
        logic [2*W-1:0]       r;
        logic [trit_bits-1:0] t;
        r = v;
        t = v[2*d +: 2];
        r[2*d +: 2] = trit_zero;
        r[2*(d-M) +: 2] = trit_add(v[2*(d-M) +: 2], t);
        r[2*(d-M+K) +: 2] = trit_add(v[2*(d-M+K) +: 2], trit_mul(t, trit_two));
        return r;
    endfunction

    wire [2*W-1:0] stage [M:W];

    // (sum a_i x^i)^3 = sum a_i x^3i in characteristic 3
    for (genvar i = 0; i < M; i++)
    begin : g_spread
        assign stage[W][6*i +: 2] = a[2*i +: 2];
        if (i < M-1)
        begin : g_gap
            assign stage[W][6*i+2 +: 4] = '0;
        end
    end

    // highest degree first, each fold lands below the trit it clears
    for (genvar d = W-1; d >= M; d--)
    begin : g_fold
        assign stage[d] = fold_step(stage[d+1], d);
    end

    assign cube = stage[M][2*M-1:0];

endmodule

`default_nettype wire

// File: logic/gf3m_execute.sv
`timescale 1ns/1ps
`default_nettype none

module gf3m_execute
    import gf3_pkg::*;
    import alu_op_pkg::*;
#(
    parameter int M = 97,
    parameter int K = 12
)
(
    input  logic           clk,
    input  logic           reset,
    exec_if.run            cmd,
    output logic           value_valid,
    output logic [2*M-1:0] value
);

    logic [2*M-1:0] sum;
    logic [2*M-1:0] diff;
    logic [2*M-1:0] neg;
    logic [2*M-1:0] cube_out;
    logic [2*M-1:0] prod;
    logic [2*M-1:0] single;
    logic [2*M-1:0] single_q;
    logic           single_valid;
    logic           mult_done;

    always_comb
    begin
        for (int i = 0; i < M; i++)
        begin
            sum[2*i +: 2]  = trit_add(cmd.a[2*i +: 2], cmd.b[2*i +: 2]);
            diff[2*i +: 2] = trit_sub(cmd.a[2*i +: 2], cmd.b[2*i +: 2]);
            neg[2*i +: 2]  = trit_neg(cmd.a[2*i +: 2]);
        end
    end

    gf3m_cube #(
        .M (M),
        .K (K)
    ) cube_inst (
        .a    (cmd.a),
        .cube (cube_out)
    );

    gf3m_mult #(
        .M (M),
        .K (K)
    ) mult_inst (
        .clk      (clk),
        .reset    (reset),
        .load     (cmd.go && (cmd.op == op_mul)),
        .a        (cmd.a),
        .b        (cmd.b),
        .product  (prod),
        .finished (mult_done)
    );

    always_comb
    begin
        case (cmd.op)
            op_add:  single = sum;
            op_sub:  single = diff;
            op_neg:  single = neg;
            op_cube: single = cube_out;
            default: single = '0; // multiply takes the other path
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            single_valid <= 1'b0;
        else
            single_valid <= cmd.go && (cmd.op != op_mul);
    end

    always_ff @(posedge clk)
    begin
        if (cmd.go)
            single_q <= single;
    end

    assign value_valid = single_valid | mult_done;
    assign value       = mult_done ? prod : single_q;

endmodule

`default_nettype wire

// File: logic/gf3m_mult.sv
`timescale 1ns/1ps
`default_nettype none

module gf3m_mult
    import gf3_pkg::*;
#(
    parameter int M = 97,
    parameter int K = 12
)
(
    input  logic           clk,
    input  logic           reset,
    input  logic           load,
    input  logic [2*M-1:0] a,
    input  logic [2*M-1:0] b,
    output logic [2*M-1:0] product,
    output logic           finished
);

    localparam int cnt_bits = $clog2(M + 1);

    logic [2*M-1:0]      x;
    logic [2*M-1:0]      y;
    logic [2*M-1:0]      acc;
    logic [2*M-1:0]      x_next;
    logic [2*M-1:0]      acc_next;
    logic [trit_bits-1:0] top;
    logic [cnt_bits-1:0] count;

    // acc + y0 * x, this is also the product on the last step
    always_comb
    begin
        for (int i = 0; i < M; i++)
            acc_next[2*i +: 2] = trit_add(acc[2*i +: 2], trit_mul(y[1:0], x[2*i +: 2]));
    end

    // x * t, with x^M folded back as 2x^K + 1
    always_comb
    begin
        top    = x[2*M-1 -: 2];
        x_next = {x[2*M-3:0], trit_zero};
        x_next[1:0] = top;
        x_next[2*K +: 2] = trit_add(x[2*(K-1) +: 2], trit_mul(top, trit_two));
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            count <= '0;
        else if (load)
            count <= cnt_bits'(M);
        else if (count != '0)
            count <= count - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            x   <= a;
            y   <= b;
            acc <= '0;
        end
        else if (count != '0)
        begin
            x   <= x_next;
            y   <= {trit_zero, y[2*M-1:2]}; // next trit of b
            acc <= acc_next;
        end
    end

    assign finished = (count == cnt_bits'(1));
    assign product  = acc_next;

endmodule

`default_nettype wire

// File: logic/op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module op_decode
    import alu_op_pkg::*;
#(
    parameter int M = 97
)
(
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic [op_bits-1:0] op,
    input  logic [2*M-1:0]     a,
    input  logic [2*M-1:0]     b,
    input  logic               value_valid,
    output logic               busy,
    exec_if.issue              cmd
);

    logic legal;
    logic accept;

    assign legal  = (op <= op_mul); // codes 5 to 7 are dropped here
    assign accept = start && !busy && legal;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy   <= 1'b0;
            cmd.go <= 1'b0;
        end
        else
        begin
            cmd.go <= accept;
            if (accept)
                busy <= 1'b1;
            else if (value_valid)
                busy <= 1'b0;
        end
    end

    // command held steady while it runs
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cmd.op <= op;
            cmd.a  <= a;
            cmd.b  <= b;
        end
    end

endmodule

`default_nettype wire

// File: logic/result_hold.sv
`timescale 1ns/1ps
`default_nettype none

module result_hold #(
    parameter int M = 97
)
(
    input  logic           clk,
    input  logic           reset,
    exec_if.watch          cmd,
    input  logic           value_valid,
    input  logic [2*M-1:0] value,
    output logic [2*M-1:0] result,
    output logic           done
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            result <= '0;
            done   <= 1'b0;
        end
        else if (value_valid)
        begin
            result <= value;
            done   <= 1'b1;
        end
        else if (cmd.go)
            done <= 1'b0; // new command under way
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+dv
logic/gf3_pkg.sv
logic/alu_op_pkg.sv
logic/exec_if.sv
logic/op_decode.sv
logic/gf3m_mult.sv
logic/gf3m_cube.sv
logic/gf3m_execute.sv
logic/result_hold.sv
logic/gf3m_alu.sv
dv/gf3m_alu_tb.sv
